// File: logic/wb_pkg.sv
package wb_pkg;

  // Bus widths
  localparam int unsigned wb_adr_w = 5;
  localparam int unsigned wb_dat_w = 32;

  // Master to slave, byte address
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [3:0]          sel;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat;
  } wb_req_t;

  // Slave to master
  // Stall stays up until the pending request is acked
  typedef struct packed {
    logic                ack;
    logic                stall;
    logic [wb_dat_w-1:0] dat;
  } wb_rsp_t;

endpackage

// File: logic/trigin_pkg.sv
package trigin_pkg;

  // Time field widths
  localparam int unsigned sec_w = 64;
  localparam int unsigned cyc_w = 32;

  // Local time or target time
  typedef struct packed {
    logic [sec_w-1:0] seconds;
    logic [cyc_w-1:0] cycles;
  } trig_time_t;

  // Byte offsets of the register map
  localparam logic [4:0] ofs_ctrl   = 5'h00;
  localparam logic [4:0] ofs_rsvd0  = 5'h04;
  localparam logic [4:0] ofs_sec_hi = 5'h08;
  localparam logic [4:0] ofs_sec_lo = 5'h0C;
  localparam logic [4:0] ofs_cycles = 5'h10;

  // Enable bit within ctrl
  localparam int unsigned ctrl_en_bit = 1;

  // Word selected by address bits [4:2]
  typedef enum logic [2:0] {
    REG_CTRL   = 3'd0,
    REG_RSVD0  = 3'd1,
    REG_SEC_HI = 3'd2,
    REG_SEC_LO = 3'd3,
    REG_CYCLES = 3'd4,
    REG_NONE   = 3'd7
  } reg_sel_e;

  function automatic reg_sel_e decode_sel(input logic [4:0] adr);
    reg_sel_e sel;
    case (adr[4:2])
      ofs_ctrl[4:2]:   sel = REG_CTRL;
      ofs_rsvd0[4:2]:  sel = REG_RSVD0;
      ofs_sec_hi[4:2]: sel = REG_SEC_HI;
      ofs_sec_lo[4:2]: sel = REG_SEC_LO;
      ofs_cycles[4:2]: sel = REG_CYCLES;
      default:         sel = REG_NONE;
    endcase
    return sel;
  endfunction

endpackage

// File: logic/trigin_regs.sv
`timescale 1ns/1ps

module trigin_regs (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  wb_pkg::wb_req_t        wb_req_i,
  output wb_pkg::wb_rsp_t        wb_rsp_o,
  input  logic                   ctrl_enable_i,
  input  trigin_pkg::trig_time_t target_i,
  output logic                   ctrl_wr_o,
  output logic                   ctrl_enable_o,
  output logic                   sec_hi_wr_o,
  output logic                   sec_lo_wr_o,
  output logic                   cycles_wr_o,
  output logic [31:0]            wr_dat_o
);

  logic                 wb_en;
  logic                 rd_req;
  logic                 wr_req;
  logic                 rip_q;
  logic                 wip_q;
  logic                 rd_ack_q;
  logic                 wr_req_q;
  logic                 ack;
  trigin_pkg::reg_sel_e rd_sel;
  trigin_pkg::reg_sel_e wr_sel_q;
  logic [31:0]          rd_dat_d;
  logic [31:0]          rd_dat_q;
  logic [31:0]          wr_dat_q;

  assign wb_en = wb_req_i.cyc & wb_req_i.stb;

  // One request per bus cycle, the master holds it until ack
  assign rd_req = wb_en & ~wb_req_i.we & ~rip_q;
  assign wr_req = wb_en & wb_req_i.we & ~wip_q;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rip_q <= 1'b0;
      wip_q <= 1'b0;
    end
    else
    begin
      rip_q <= (rip_q | (wb_en & ~wb_req_i.we)) & ~rd_ack_q;
      wip_q <= (wip_q | (wb_en & wb_req_i.we)) & ~wr_req_q;
    end
  end

  // Request stage to ack stage
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      rd_ack_q <= 1'b0;
      wr_req_q <= 1'b0;
    end
    else
    begin
      rd_ack_q <= rd_req;
      wr_req_q <= wr_req;
    end
  end

  always_ff @(posedge clk_i)
  begin
    rd_dat_q <= rd_dat_d;
    wr_sel_q <= trigin_pkg::decode_sel(wb_req_i.adr);
    wr_dat_q <= wb_req_i.dat;
  end

  // Write ack comes with the strobe
  assign ack = rd_ack_q | wr_req_q;

  assign wb_rsp_o.ack   = ack;
  assign wb_rsp_o.stall = wb_en & ~ack;
  assign wb_rsp_o.dat   = rd_dat_q;

  // Read mux, unmapped words read zero
  assign rd_sel = trigin_pkg::decode_sel(wb_req_i.adr);

  always_comb
  begin
    rd_dat_d = '0;
    case (rd_sel)
      trigin_pkg::REG_CTRL:   rd_dat_d[trigin_pkg::ctrl_en_bit] = ctrl_enable_i;
      trigin_pkg::REG_SEC_HI: rd_dat_d = target_i.seconds[63:32];
      trigin_pkg::REG_SEC_LO: rd_dat_d = target_i.seconds[31:0];
      trigin_pkg::REG_CYCLES: rd_dat_d = target_i.cycles;
      default:                rd_dat_d = '0;
    endcase
  end

  // Per register write strobes
  assign ctrl_wr_o   = wr_req_q & (wr_sel_q == trigin_pkg::REG_CTRL);
  assign sec_hi_wr_o = wr_req_q & (wr_sel_q == trigin_pkg::REG_SEC_HI);
  assign sec_lo_wr_o = wr_req_q & (wr_sel_q == trigin_pkg::REG_SEC_LO);
  assign cycles_wr_o = wr_req_q & (wr_sel_q == trigin_pkg::REG_CYCLES);

  assign ctrl_enable_o = wr_dat_q[trigin_pkg::ctrl_en_bit];
  assign wr_dat_o      = wr_dat_q;

  // Ack only answers a live bus cycle
  ack_needs_cyc: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wb_rsp_o.ack |-> wb_req_i.cyc
  );

  strobe_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({ctrl_wr_o, sec_hi_wr_o, sec_lo_wr_o, cycles_wr_o})
  );

endmodule

// File: logic/time_base.sv
`timescale 1ns/1ps

module time_base #(
  parameter int unsigned cycles_per_sec = 125000000
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  output trigin_pkg::trig_time_t now_o
);

  localparam logic [trigin_pkg::cyc_w-1:0] last_cyc = cycles_per_sec - 1;

  trigin_pkg::trig_time_t now_q;
  logic                   wrap;

  // Last cycle of the current second
  assign wrap = (now_q.cycles == last_cyc);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      now_q <= '0;
    end
    else if (wrap)
    begin
      now_q.cycles  <= '0;
      now_q.seconds <= now_q.seconds + 1'b1;
    end
    else
    begin
      now_q.cycles <= now_q.cycles + 1'b1;
    end
  end

  assign now_o = now_q;

  cycles_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    now_q.cycles < cycles_per_sec
  );

endmodule

// File: logic/trigin_core.sv
`timescale 1ns/1ps

module trigin_core #(
  parameter int unsigned cycles_per_sec = 125000000
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  trigin_pkg::trig_time_t now_i,
  input  logic                   ctrl_wr_i,
  input  logic                   ctrl_enable_i,
  input  logic                   sec_hi_wr_i,
  input  logic                   sec_lo_wr_i,
  input  logic                   cycles_wr_i,
  input  logic [31:0]            wr_dat_i,
  output logic                   enable_o,
  output trigin_pkg::trig_time_t target_o,
  output logic                   trig_o
);

  trigin_pkg::trig_time_t target_q;
  logic                   enable_q;
  logic                   trig_q;
  logic                   sec_after;
  logic                   sec_equal;
  logic                   fire;

  // Target time, seconds written as two halves
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      target_q <= '0;
    end
    else
    begin
      if (sec_hi_wr_i)
        target_q.seconds[63:32] <= wr_dat_i;
      if (sec_lo_wr_i)
        target_q.seconds[31:0] <= wr_dat_i;
      if (cycles_wr_i)
        target_q.cycles <= wr_dat_i;
    end
  end

  // Seconds first, cycles only break a tie
  assign sec_after = now_i.seconds > target_q.seconds;
  assign sec_equal = now_i.seconds == target_q.seconds;
  assign fire      = enable_q & (sec_after | (sec_equal & (now_i.cycles >= target_q.cycles)));

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      enable_q <= 1'b0;
      trig_q   <= 1'b0;
    end
    else
    begin
      trig_q <= fire;
      // Firing beats a ctrl write on the same edge
      if (fire)
        enable_q <= 1'b0;
      else if (ctrl_wr_i)
        enable_q <= ctrl_enable_i;
    end
  end

  assign enable_o = enable_q;
  assign target_o = target_q;
  assign trig_o   = trig_q;

  target_cycles_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    target_q.cycles < cycles_per_sec
  );

  // Enable drops with the pulse, so no second pulse follows
  single_pulse: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    trig_q |=> !trig_q
  );

endmodule

// File: logic/trigin_top.sv
`timescale 1ns/1ps

module trigin_top #(
  parameter int unsigned cycles_per_sec = 125000000
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  wb_pkg::wb_req_t        wb_req_i,
  output wb_pkg::wb_rsp_t        wb_rsp_o,
  output trigin_pkg::trig_time_t now_o,
  output logic                   trig_o
);

  logic                   ctrl_wr;
  logic                   ctrl_enable_wr;
  logic                   sec_hi_wr;
  logic                   sec_lo_wr;
  logic                   cycles_wr;
  logic [31:0]            wr_dat;
  logic                   enable;
  trigin_pkg::trig_time_t target;

  trigin_regs trigin_regs_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .wb_req_i      (wb_req_i),
    .wb_rsp_o      (wb_rsp_o),
    .ctrl_enable_i (enable),
    .target_i      (target),
    .ctrl_wr_o     (ctrl_wr),
    .ctrl_enable_o (ctrl_enable_wr),
    .sec_hi_wr_o   (sec_hi_wr),
    .sec_lo_wr_o   (sec_lo_wr),
    .cycles_wr_o   (cycles_wr),
    .wr_dat_o      (wr_dat)
  );

  time_base #(
    .cycles_per_sec (cycles_per_sec)
  ) time_base_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .now_o   (now_o)
  );

  // Local time feeds the core and leaves the top as now_o
  trigin_core #(
    .cycles_per_sec (cycles_per_sec)
  ) trigin_core_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .now_i         (now_o),
    .ctrl_wr_i     (ctrl_wr),
    .ctrl_enable_i (ctrl_enable_wr),
    .sec_hi_wr_i   (sec_hi_wr),
    .sec_lo_wr_i   (sec_lo_wr),
    .cycles_wr_i   (cycles_wr),
    .wr_dat_i      (wr_dat),
    .enable_o      (enable),
    .target_o      (target),
    .trig_o        (trig_o)
  );

endmodule

// File: sim/tb_trigin.sv
`timescale 1ns/1ps

module tb_trigin;

  localparam int unsigned cps         = 50;
  localparam int          ack_timeout = 8;

  logic                   clk;
  logic                   rst_n;
  wb_pkg::wb_req_t        wb_req;
  wb_pkg::wb_rsp_t        wb_rsp;
  trigin_pkg::trig_time_t now;
  logic                   trig;

  // Model of the target registers written by write_target
  logic [63:0]            exp_sec;
  logic [31:0]            exp_cyc;
  // Set only while a pulse is expected
  logic                   fire_allowed;
  logic [4:0]             unmapped [3];

  trigin_top #(
    .cycles_per_sec (cps)
  ) trigin_top_i (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp),
    .now_o    (now),
    .trig_o   (trig)
  );

  always #20 clk = ~clk;

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual == expected)
    else
      abort_run($sformatf("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual));
  endtask

  // One Wishbone cycle with ack expected one cycle after the request
  task automatic bus_transfer(input logic we, input logic [4:0] adr,
                              input logic [31:0] wdat, output logic [31:0] rdat);
    wb_pkg::wb_req_t req;
    int              waited;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.sel = 4'hF;
    req.adr = adr;
    req.dat = wdat;
    waited  = 0;
    @(posedge clk);
    wb_req <= req;
    @(negedge clk);
    while (!wb_rsp.ack && waited <= ack_timeout)
    begin
      check_value("wb_rsp.stall", 1, wb_rsp.stall);
      waited++;
      @(negedge clk);
    end
    if (!wb_rsp.ack)
      abort_run("Timed out waiting for the Wishbone ack");
    check_value("ack latency", 1, waited);
    rdat = wb_rsp.dat;
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic wb_write(input logic [4:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_transfer(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input logic [4:0] adr, output logic [31:0] dat);
    bus_transfer(1'b0, adr, 32'h0, dat);
  endtask

  task automatic expect_read(input string name, input logic [4:0] adr,
                             input logic [31:0] expected);
    logic [31:0] dat;
    wb_read(adr, dat);
    check_value(name, expected, dat);
  endtask

  task automatic write_target(input logic [63:0] sec, input logic [31:0] cyc);
    wb_write(trigin_pkg::ofs_sec_hi, sec[63:32]);
    wb_write(trigin_pkg::ofs_sec_lo, sec[31:0]);
    wb_write(trigin_pkg::ofs_cycles, cyc);
    exp_sec = sec;
    exp_cyc = cyc;
  endtask

  task automatic check_target_regs();
    expect_read("sec_hi", trigin_pkg::ofs_sec_hi, exp_sec[63:32]);
    expect_read("sec_lo", trigin_pkg::ofs_sec_lo, exp_sec[31:0]);
    expect_read("cycles", trigin_pkg::ofs_cycles, exp_cyc);
  endtask

  // Counts the low cycles seen at falling edges before the pulse
  task automatic wait_trigger(input int limit, output int waited);
    waited = 0;
    @(negedge clk);
    while (!trig && waited <= limit)
    begin
      waited++;
      @(negedge clk);
    end
    if (!trig)
      abort_run("Timed out waiting for the trigger pulse");
  endtask

  // Bus protocol and trigger gating
  ack_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) wb_rsp.ack |=> !wb_rsp.ack)
    else abort_run($sformatf("ERR %0t wb_rsp.ack expected 0 actual 1", $time));

  ack_not_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    !(wb_rsp.ack && wb_rsp.stall))
    else abort_run($sformatf("ERR %0t wb_rsp.stall expected 0 actual 1", $time));

  trig_when_armed: assert property (@(posedge clk) disable iff (!rst_n) trig |-> fire_allowed)
    else abort_run($sformatf("ERR %0t trig_o expected 0 actual 1", $time));

  initial
  begin
    trigin_pkg::trig_time_t cur;
    logic [31:0]            rdat;
    int                     waited;
    clk          = 1'b0;
    rst_n        = 1'b0;
    wb_req       = '0;
    fire_allowed = 1'b0;
    exp_sec      = '0;
    exp_cyc      = '0;
    unmapped     = '{5'h04, 5'h14, 5'h1C};
    void'($urandom(32'h6dd2761e));
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // Reset state
    @(negedge clk);
    check_value("trig_o", 0, trig);
    check_value("wb_rsp.ack", 0, wb_rsp.ack);
    expect_read("ctrl", trigin_pkg::ofs_ctrl, 32'h0);
    check_target_regs();

    // Readback of random targets
    for (int i = 0; i < 3; i++)
    begin
      write_target({$urandom, $urandom}, $urandom % cps);
      check_target_regs();
    end

    // Timed firing three seconds ahead with the pulse one cycle after the target
    @(negedge clk);
    cur = now;
    write_target(cur.seconds + 3, 17);
    fire_allowed = 1'b1;
    wb_write(trigin_pkg::ofs_ctrl, 32'h2);
    wait_trigger(5 * cps, waited);
    check_value("now_o.seconds", exp_sec, now.seconds);
    check_value("now_o.cycles", 18, now.cycles);
    @(negedge clk);
    check_value("trig_o", 0, trig);
    fire_allowed = 1'b0;
    expect_read("ctrl", trigin_pkg::ofs_ctrl, 32'h0);

    // Target already passed
    // Enable lands at the end of the ack cycle and the pulse follows one edge later
    @(negedge clk);
    cur = now;
    write_target(cur.seconds - 1, 0);
    fire_allowed = 1'b1;
    wb_write(trigin_pkg::ofs_ctrl, 32'h2);
    wait_trigger(4, waited);
    check_value("cycles before trig_o", 1, waited);
    @(negedge clk);
    fire_allowed = 1'b0;
    expect_read("ctrl", trigin_pkg::ofs_ctrl, 32'h0);

    // Disabled before the target so no pulse through the target time
    @(negedge clk);
    cur = now;
    write_target(cur.seconds + 2, 5);
    wb_write(trigin_pkg::ofs_ctrl, 32'h2);
    expect_read("ctrl", trigin_pkg::ofs_ctrl, 32'h2);
    wb_write(trigin_pkg::ofs_ctrl, 32'h0);
    waited = 0;
    while (now.seconds <= exp_sec && waited <= 4 * cps)
    begin
      waited++;
      @(negedge clk);
    end
    if (now.seconds <= exp_sec)
      abort_run("Timed out waiting for local time to pass the target");
    expect_read("ctrl", trigin_pkg::ofs_ctrl, 32'h0);

    // Unmapped words read zero and ignore writes
    foreach (unmapped[i])
      expect_read($sformatf("rd_dat@%0h", unmapped[i]), unmapped[i], 32'h0);
    foreach (unmapped[i])
      wb_write(unmapped[i], $urandom);
    foreach (unmapped[i])
      expect_read($sformatf("rd_dat@%0h", unmapped[i]), unmapped[i], 32'h0);
    expect_read("ctrl", trigin_pkg::ofs_ctrl, 32'h0);
    check_target_regs();

    repeat (2) @(posedge clk);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: tb.f
logic/wb_pkg.sv
logic/trigin_pkg.sv
logic/trigin_regs.sv
logic/time_base.sv
logic/trigin_core.sv
logic/trigin_top.sv
sim/tb_trigin.sv

// File: Makefile
# Verilator simulation of the timed trigger unit

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_trigin
FILELIST  ?= tb.f
LOG       ?= sim.log

.PHONY: sim clean

# Pass or fail is taken from the log, not from the exit code of the run
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
